//--- flist.f
+incdir+logic
logic/sp_types_pkg.sv
logic/wb_ctrl_pkg.sv
logic/row_fifo.sv
logic/tile_collector.sv
logic/dramstore_fsm.sv
logic/store_writeback.sv
verif/store_writeback_checker.sv
verif/store_writeback_tb.sv

//--- logic/dramstore_fsm.sv
`include "sp_cfg.svh"

module dramstore_fsm
    import sp_types_pkg::*;
(
    input  logic     empty0,
    input  logic     empty1,
    input  logic     empty2,
    input  logic     empty3,
    input  addr_t    head_addr0,
    input  addr_t    head_addr1,
    input  addr_t    head_addr2,
    input  addr_t    head_addr3,
    input  row_t     head_data0,
    input  row_t     head_data1,
    input  row_t     head_data2,
    input  row_t     head_data3,
    input  row_idx_t head_row0,
    input  row_idx_t head_row1,
    input  row_idx_t head_row2,
    input  row_idx_t head_row3,
    input  logic     store_hit,
    output logic     pop0,
    output logic     pop1,
    output logic     pop2,
    output logic     pop3,
    output logic     store_req,
    output addr_t    store_addr,
    output row_t     store_data,
    output logic     store_complete
);

    slot_t    sel;
    addr_t    sel_addr;
    row_t     sel_data;
    row_idx_t sel_row;
    logic     any_valid;
    logic     accept;

    // fixed priority, lowest slot wins
    always_comb begin
        any_valid = 1'b1;
        sel       = '0;
        sel_addr  = '0;
        sel_data  = '0;
        sel_row   = '0;
        if (!empty0) begin
            sel_addr = head_addr0;
            sel_data = head_data0;
            sel_row  = head_row0;
        end else if (!empty1) begin
            sel      = slot_t'(1);
            sel_addr = head_addr1;
            sel_data = head_data1;
            sel_row  = head_row1;
        end else if (!empty2) begin
            sel      = slot_t'(2);
            sel_addr = head_addr2;
            sel_data = head_data2;
            sel_row  = head_row2;
        end else if (!empty3) begin
            sel      = slot_t'(3);
            sel_addr = head_addr3;
            sel_data = head_data3;
            sel_row  = head_row3;
        end else begin
            any_valid = 1'b0;
        end
    end

    // request held at the head until the memory takes it
    assign store_req  = any_valid;
    assign store_addr = sel_addr + addr_t'(`SP_STRIDE) * addr_t'(sel_row);
    assign store_data = sel_data;

    assign accept = any_valid && store_hit;

    assign pop0 = accept && (sel == slot_t'(0));
    assign pop1 = accept && (sel == slot_t'(1));
    assign pop2 = accept && (sel == slot_t'(2));
    assign pop3 = accept && (sel == slot_t'(3));

    // last row of the tile accepted
    assign store_complete = accept && (sel_row == row_idx_t'(`SP_ROWS-1));

endmodule

//--- logic/row_fifo.sv
`include "sp_cfg.svh"

module row_fifo
    import sp_types_pkg::*;
#(
    parameter int DEPTH = `SP_FIFO_DEPTH
) (
    input  logic     CLK,
    input  logic     rst_n,
    input  logic     push,
    input  addr_t    wr_addr,
    input  row_t     wr_data,
    input  row_idx_t wr_row,
    input  logic     pop,
    output addr_t    rd_addr,
    output row_t     rd_data,
    output row_idx_t rd_row,
    output logic     empty,
    output logic     full
);

    localparam int PTR_W = $clog2(DEPTH);

    // one array per field of a tagged row
    addr_t    addr_mem [DEPTH];
    row_t     data_mem [DEPTH];
    row_idx_t row_mem  [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    // no write when full, no read when empty
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign empty = (count == '0);
    assign full  = (count == (PTR_W+1)'(DEPTH));

    always_ff @(posedge CLK) begin
        if (do_push) begin
            addr_mem[wr_ptr] <= wr_addr;
            data_mem[wr_ptr] <= wr_data;
            row_mem[wr_ptr]  <= wr_row;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // show-ahead head, valid whenever empty is low
    assign rd_addr = addr_mem[rd_ptr];
    assign rd_data = data_mem[rd_ptr];
    assign rd_row  = row_mem[rd_ptr];

endmodule

//--- logic/sp_cfg.svh
`ifndef SP_CFG_SVH
`define SP_CFG_SVH

// dram byte address width
`define SP_ADDR_W 32
// one result row, four 16-bit results
`define SP_DATA_W 64

// entries per slot fifo, room for two tiles
`define SP_FIFO_DEPTH 8
`define SP_SLOTS 4

// byte distance between tile rows
`define SP_STRIDE 64
`define SP_ROWS 4

`endif

//--- logic/sp_types_pkg.sv
`include "sp_cfg.svh"

package sp_types_pkg;

    // dram byte address
    typedef logic [`SP_ADDR_W-1:0] addr_t;

    // one result row from the array
    typedef logic [`SP_DATA_W-1:0] row_t;

    // row number inside a tile, slot fifo number
    typedef logic [$clog2(`SP_ROWS)-1:0] row_idx_t;
    typedef logic [$clog2(`SP_SLOTS)-1:0] slot_t;

endpackage

//--- logic/store_writeback.sv
`include "sp_cfg.svh"

module store_writeback
    import sp_types_pkg::*;
(
    input  logic                 CLK,
    input  logic                 rst_n,
    input  logic                 tile_start,
    input  slot_t                tile_slot,
    input  addr_t                tile_addr,
    input  logic                 row_valid,
    input  row_t                 row_data,
    input  logic                 store_hit,
    output logic                 store_req,
    output addr_t                store_addr,
    output row_t                 store_data,
    output logic                 store_complete,
    output logic [`SP_SLOTS-1:0] slot_full,
    output logic                 collecting
);

    // collector to fifos
    logic [`SP_SLOTS-1:0] fifo_push;
    addr_t                fifo_waddr;
    row_t                 fifo_wdata;
    row_idx_t             fifo_wrow;

    // fifo heads to the drain logic
    logic [`SP_SLOTS-1:0] fifo_empty;
    logic [`SP_SLOTS-1:0] fifo_pop;
    addr_t                head_addr [`SP_SLOTS];
    row_t                 head_data [`SP_SLOTS];
    row_idx_t             head_row  [`SP_SLOTS];

    tile_collector i_collector (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .tile_start (tile_start),
        .tile_slot  (tile_slot),
        .tile_addr  (tile_addr),
        .row_valid  (row_valid),
        .row_data   (row_data),
        .push       (fifo_push),
        .wr_addr    (fifo_waddr),
        .wr_data    (fifo_wdata),
        .wr_row     (fifo_wrow),
        .collecting (collecting)
    );

    row_fifo #(.DEPTH(`SP_FIFO_DEPTH)) i_fifo0 (
        .CLK(CLK), .rst_n(rst_n),
        .push(fifo_push[0]), .wr_addr(fifo_waddr), .wr_data(fifo_wdata), .wr_row(fifo_wrow),
        .pop(fifo_pop[0]),
        .rd_addr(head_addr[0]), .rd_data(head_data[0]), .rd_row(head_row[0]),
        .empty(fifo_empty[0]), .full(slot_full[0])
    );

    row_fifo #(.DEPTH(`SP_FIFO_DEPTH)) i_fifo1 (
        .CLK(CLK), .rst_n(rst_n),
        .push(fifo_push[1]), .wr_addr(fifo_waddr), .wr_data(fifo_wdata), .wr_row(fifo_wrow),
        .pop(fifo_pop[1]),
        .rd_addr(head_addr[1]), .rd_data(head_data[1]), .rd_row(head_row[1]),
        .empty(fifo_empty[1]), .full(slot_full[1])
    );

    row_fifo #(.DEPTH(`SP_FIFO_DEPTH)) i_fifo2 (
        .CLK(CLK), .rst_n(rst_n),
        .push(fifo_push[2]), .wr_addr(fifo_waddr), .wr_data(fifo_wdata), .wr_row(fifo_wrow),
        .pop(fifo_pop[2]),
        .rd_addr(head_addr[2]), .rd_data(head_data[2]), .rd_row(head_row[2]),
        .empty(fifo_empty[2]), .full(slot_full[2])
    );

    row_fifo #(.DEPTH(`SP_FIFO_DEPTH)) i_fifo3 (
        .CLK(CLK), .rst_n(rst_n),
        .push(fifo_push[3]), .wr_addr(fifo_waddr), .wr_data(fifo_wdata), .wr_row(fifo_wrow),
        .pop(fifo_pop[3]),
        .rd_addr(head_addr[3]), .rd_data(head_data[3]), .rd_row(head_row[3]),
        .empty(fifo_empty[3]), .full(slot_full[3])
    );

    // drain to the memory store port
    dramstore_fsm i_drain (
        .empty0         (fifo_empty[0]),
        .empty1         (fifo_empty[1]),
        .empty2         (fifo_empty[2]),
        .empty3         (fifo_empty[3]),
        .head_addr0     (head_addr[0]),
        .head_addr1     (head_addr[1]),
        .head_addr2     (head_addr[2]),
        .head_addr3     (head_addr[3]),
        .head_data0     (head_data[0]),
        .head_data1     (head_data[1]),
        .head_data2     (head_data[2]),
        .head_data3     (head_data[3]),
        .head_row0      (head_row[0]),
        .head_row1      (head_row[1]),
        .head_row2      (head_row[2]),
        .head_row3      (head_row[3]),
        .store_hit      (store_hit),
        .pop0           (fifo_pop[0]),
        .pop1           (fifo_pop[1]),
        .pop2           (fifo_pop[2]),
        .pop3           (fifo_pop[3]),
        .store_req      (store_req),
        .store_addr     (store_addr),
        .store_data     (store_data),
        .store_complete (store_complete)
    );

endmodule

//--- logic/tile_collector.sv
`include "sp_cfg.svh"

module tile_collector
    import sp_types_pkg::*;
    import wb_ctrl_pkg::*;
(
    input  logic                 CLK,
    input  logic                 rst_n,
    input  logic                 tile_start,
    input  slot_t                tile_slot,
    input  addr_t                tile_addr,
    input  logic                 row_valid,
    input  row_t                 row_data,
    output logic [`SP_SLOTS-1:0] push,
    output addr_t                wr_addr,
    output row_t                 wr_data,
    output row_idx_t             wr_row,
    output logic                 collecting
);

    coll_state_t state;
    coll_state_t state_nxt;

    slot_t    slot_q;
    addr_t    base_q;
    row_idx_t row_cnt;

    logic                 take_tile;
    logic                 take_row;
    logic                 last_row;
    logic [`SP_SLOTS-1:0] push_nxt;

    // start ignored while collecting, rows ignored while idle
    assign take_tile = (state == COLL_IDLE) && tile_start;
    assign take_row  = (state == COLL_ROWS) && row_valid;
    assign last_row  = (row_cnt == row_idx_t'(`SP_ROWS-1));

    assign collecting = (state == COLL_ROWS);

    always_comb begin
        state_nxt = state;
        case (state)
            COLL_IDLE: begin
                if (tile_start) begin
                    state_nxt = COLL_ROWS;
                end
            end
            COLL_ROWS: begin
                if (row_valid && last_row) begin
                    state_nxt = COLL_IDLE;
                end
            end
            default: state_nxt = COLL_IDLE;
        endcase
    end

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            state   <= COLL_IDLE;
            slot_q  <= '0;
            row_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (take_tile) begin
                slot_q  <= tile_slot;
                row_cnt <= '0;
            end else if (take_row) begin
                row_cnt <= row_cnt + 1'b1;
            end
        end
    end

    // base address of the current tile
    always_ff @(posedge CLK) begin
        if (take_tile) begin
            base_q <= tile_addr;
        end
    end

    // one push bit, for the latched slot only
    always_comb begin
        for (int i = 0; i < `SP_SLOTS; i++) begin
            push_nxt[i] = take_row && (slot_q == slot_t'(i));
        end
    end

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            push <= '0;
        end else begin
            push <= push_nxt;
        end
    end

    // write fields shared by all slot fifos
    always_ff @(posedge CLK) begin
        if (take_row) begin
            wr_addr <= base_q;
            wr_data <= row_data;
            wr_row  <= row_cnt;
        end
    end

endmodule

//--- logic/wb_ctrl_pkg.sv
package wb_ctrl_pkg;

    // tile collector states
    typedef enum logic {
        COLL_IDLE,
        COLL_ROWS
    } coll_state_t;

endpackage

//--- verif/store_writeback_checker.sv
`include "sp_cfg.svh"

module store_writeback_checker
    import sp_types_pkg::*;
    import wb_ctrl_pkg::*;
(
    input logic                 CLK,
    input logic                 rst_n,
    input logic                 store_req,
    input logic                 store_hit,
    input addr_t                store_addr,
    input row_t                 store_data,
    input logic                 store_complete,
    input logic [`SP_SLOTS-1:0] slot_full,
    input logic [`SP_SLOTS-1:0] fifo_push,
    input logic [`SP_SLOTS-1:0] fifo_pop
);

    // the head may only switch when a row enters a lower slot
    a_req_stable: assert property (@(posedge CLK) disable iff (!rst_n)
        (store_req && !store_hit && fifo_push == '0)
            |=> ($stable(store_addr) && $stable(store_data)))
        else $error("store request changed while waiting for the memory");

    a_complete_hit: assert property (@(posedge CLK) disable iff (!rst_n)
        store_complete |-> store_hit)
        else $error("store_complete raised without store_hit");

    a_push_full: assert property (@(posedge CLK) disable iff (!rst_n)
        (fifo_push & slot_full) == '0)
        else $error("row pushed into a full slot fifo");

    a_pop_req: assert property (@(posedge CLK) disable iff (!rst_n)
        (fifo_pop != '0) |-> store_req)
        else $error("row accepted without store_req");

endmodule

bind store_writeback store_writeback_checker i_checker (
    .CLK            (CLK),
    .rst_n          (rst_n),
    .store_req      (store_req),
    .store_hit      (store_hit),
    .store_addr     (store_addr),
    .store_data     (store_data),
    .store_complete (store_complete),
    .slot_full      (slot_full),
    .fifo_push      (fifo_push),
    .fifo_pop       (fifo_pop)
);

//--- verif/store_writeback_tb.sv
`include "sp_cfg.svh"

module store_writeback_tb
    import sp_types_pkg::*;
();

    localparam int N_TILES = 23;
    localparam int TIMEOUT = 20 * N_TILES + 200;
    localparam int DEPTH   = `SP_FIFO_DEPTH;

    logic                 CLK;
    logic                 rst_n;
    logic                 tile_start;
    slot_t                tile_slot;
    addr_t                tile_addr;
    logic                 row_valid;
    row_t                 row_data;
    logic                 store_hit;
    logic                 store_req;
    addr_t                store_addr;
    row_t                 store_data;
    logic                 store_complete;
    logic [`SP_SLOTS-1:0] slot_full;
    logic                 collecting;

    // stimulus table, one tile per entry
    int    tbl_phase [N_TILES];
    slot_t tbl_slot  [N_TILES];
    addr_t tbl_base  [N_TILES];
    row_t  tbl_row   [N_TILES][`SP_ROWS];

    // memory mode: 0 held low, 1 held high, 2 random
    int hit_mode;

    // rows on their way into a slot fifo
    int    pend_ready [$];
    int    pend_slot  [$];
    addr_t pend_addr  [$];
    row_t  pend_data  [$];
    int    pend_row   [$];

    // expected contents of each slot fifo
    addr_t m_addr [`SP_SLOTS][DEPTH];
    row_t  m_data [`SP_SLOTS][DEPTH];
    int    m_row  [`SP_SLOTS][DEPTH];
    int    m_head [`SP_SLOTS];
    int    m_cnt  [`SP_SLOTS];

    int cyc;
    int n_accept;
    int n_complete;
    int tiles_sent;
    int acc_slot [$];
    int sel;
    int h;
    int w;

    store_writeback i_dut (
        .CLK            (CLK),
        .rst_n          (rst_n),
        .tile_start     (tile_start),
        .tile_slot      (tile_slot),
        .tile_addr      (tile_addr),
        .row_valid      (row_valid),
        .row_data       (row_data),
        .store_hit      (store_hit),
        .store_req      (store_req),
        .store_addr     (store_addr),
        .store_data     (store_data),
        .store_complete (store_complete),
        .slot_full      (slot_full),
        .collecting     (collecting)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    task automatic compare_val(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("error at time %0t: %s, got %h expected %h", $time, what, got, exp);
            $display("Some tests failed");
            $fatal(1, "mismatch");
        end
    endtask

    // memory model
    always @(posedge CLK) begin
        case (hit_mode)
            0:       store_hit <= 1'b0;
            1:       store_hit <= 1'b1;
            default: store_hit <= 1'($urandom % 2);
        endcase
    end

    // scoreboard, samples mid-cycle when the store port is settled
    always @(negedge CLK) begin
        if (rst_n) begin
            cyc = cyc + 1;
            if (cyc > TIMEOUT) begin
                $display("the run timed out after %0d cycles", cyc);
                $display("Some tests failed");
                $fatal(1, "timeout");
            end
            // a row shows up at its fifo head two cycles after the push
            while (pend_ready.size() > 0 && pend_ready[0] <= cyc) begin
                w = (m_head[pend_slot[0]] + m_cnt[pend_slot[0]]) % DEPTH;
                m_addr[pend_slot[0]][w] = pend_addr[0];
                m_data[pend_slot[0]][w] = pend_data[0];
                m_row[pend_slot[0]][w]  = pend_row[0];
                m_cnt[pend_slot[0]]++;
                void'(pend_ready.pop_front());
                void'(pend_slot.pop_front());
                void'(pend_addr.pop_front());
                void'(pend_data.pop_front());
                void'(pend_row.pop_front());
            end
            sel = -1;
            for (int s = `SP_SLOTS - 1; s >= 0; s--) begin
                if (m_cnt[s] > 0) begin
                    sel = s;
                end
            end
            compare_val(64'(store_req), 64'(sel >= 0), "store_req against queued rows");
            if (store_req && store_hit) begin
                h = m_head[sel];
                compare_val(64'(store_addr), 64'(m_addr[sel][h]), "store address");
                compare_val(store_data, m_data[sel][h], "store data");
                compare_val(64'(store_complete), 64'(m_row[sel][h] == `SP_ROWS - 1),
                            "store_complete on accepted row");
                m_head[sel] = (h + 1) % DEPTH;
                m_cnt[sel]--;
                n_accept++;
                acc_slot.push_back(sel);
            end else begin
                compare_val(64'(store_complete), 64'd0, "store_complete without acceptance");
            end
            if (store_complete) begin
                n_complete++;
            end
        end
    end

    function automatic int queued_rows();
        int n;
        n = pend_ready.size();
        for (int s = 0; s < `SP_SLOTS; s++) begin
            n += m_cnt[s];
        end
        return n;
    endfunction

    task automatic wait_idle();
        while (queued_rows() > 0) begin
            @(posedge CLK);
        end
    endtask

    // never start a tile without four free entries in its slot
    task automatic wait_room(input int slot);
        int used;
        used = DEPTH;
        while (used > DEPTH - `SP_ROWS) begin
            @(posedge CLK);
            used = m_cnt[slot];
            foreach (pend_slot[k]) begin
                if (pend_slot[k] == slot) begin
                    used++;
                end
            end
        end
    endtask

    task automatic send_tile(input int idx);
        wait_room(int'(tbl_slot[idx]));
        tile_start <= 1'b1;
        tile_slot  <= tbl_slot[idx];
        tile_addr  <= tbl_base[idx];
        @(posedge CLK);
        tile_start <= 1'b0;
        for (int r = 0; r < `SP_ROWS; r++) begin
            row_valid <= 1'b1;
            row_data  <= tbl_row[idx][r];
            pend_ready.push_back(cyc + 3);
            pend_slot.push_back(int'(tbl_slot[idx]));
            pend_addr.push_back(tbl_base[idx] + addr_t'(`SP_STRIDE * r));
            pend_data.push_back(tbl_row[idx][r]);
            pend_row.push_back(r);
            @(negedge CLK);
            compare_val(64'(collecting), 64'd1, "collecting while rows arrive");
            @(posedge CLK);
        end
        row_valid <= 1'b0;
        @(negedge CLK);
        compare_val(64'(collecting), 64'd0, "collecting after the last row");
        tiles_sent++;
    endtask

    task automatic build_table();
        for (int i = 0; i < N_TILES; i++) begin
            tbl_phase[i] = (i == 0) ? 2 : (i < 5) ? 3 : (i < 21) ? 4 : 6;
            tbl_base[i]  = 32'h8000_0000 + 32'(i) * 32'h1000;
            tbl_slot[i]  = slot_t'($urandom_range(3, 0));
            for (int r = 0; r < `SP_ROWS; r++) begin
                tbl_row[i][r] = {$urandom, $urandom};
            end
            if (tbl_phase[i] == 4) begin
                tbl_base[i] = $urandom & 32'hFFFF_F000;
            end
        end
        tbl_slot[0]  = 2'd0;
        tbl_slot[1]  = 2'd3;
        tbl_slot[2]  = 2'd1;
        tbl_slot[3]  = 2'd0;
        tbl_slot[4]  = 2'd2;
        tbl_slot[21] = 2'd2;
        tbl_slot[22] = 2'd2;
    endtask

    task automatic start_phase(input int phase);
        wait_idle();
        case (phase)
            2:       hit_mode <= 1;
            4:       hit_mode <= 2;
            default: hit_mode <= 0;
        endcase
        acc_slot.delete();
    endtask

    task automatic finish_phase(input int phase, input int idx);
        int start;
        if (phase == 3) begin
            hit_mode <= 1;
            wait_idle();
            compare_val(64'(acc_slot.size()), 64'd16, "row count after slot priority test");
            for (int k = 0; k < 16; k++) begin
                compare_val(64'(acc_slot[k]), 64'(k / 4), "slot order under priority");
            end
        end else if (phase == 6) begin
            while (pend_ready.size() > 0) begin
                @(posedge CLK);
            end
            @(negedge CLK);
            compare_val(64'(slot_full), 64'(1 << tbl_slot[idx]), "slot_full with two tiles");
            start = n_accept;
            hit_mode <= 1;
            while (n_accept == start) begin
                @(posedge CLK);
            end
            @(negedge CLK);
            compare_val(64'(slot_full), 64'd0, "slot_full after first store");
        end
        wait_idle();
    endtask

    initial begin
        tile_start = 1'b0;
        tile_slot  = '0;
        tile_addr  = '0;
        row_valid  = 1'b0;
        row_data   = '0;
        store_hit  = 1'b0;
        rst_n      = 1'b0;
        hit_mode   = 0;
        cyc        = 0;
        n_accept   = 0;
        n_complete = 0;
        tiles_sent = 0;
        for (int s = 0; s < `SP_SLOTS; s++) begin
            m_head[s] = 0;
            m_cnt[s]  = 0;
        end
        void'($urandom(78));
        build_table();

        repeat (8) @(posedge CLK);
        rst_n <= 1'b1;
        @(negedge CLK);
        compare_val(64'(store_req), 64'd0, "store_req after reset");
        compare_val(64'(store_complete), 64'd0, "store_complete after reset");
        compare_val(64'(collecting), 64'd0, "collecting after reset");
        compare_val(64'(slot_full), 64'd0, "slot_full after reset");

        // rows while idle must be dropped
        @(posedge CLK);
        for (int r = 0; r < 3; r++) begin
            row_valid <= 1'b1;
            row_data  <= {$urandom, $urandom};
            @(posedge CLK);
        end
        row_valid <= 1'b0;
        repeat (6) @(posedge CLK);

        for (int i = 0; i < N_TILES; i++) begin
            if (i == 0 || tbl_phase[i] != tbl_phase[i-1]) begin
                if (i != 0) begin
                    finish_phase(tbl_phase[i-1], i - 1);
                end
                start_phase(tbl_phase[i]);
            end
            send_tile(i);
        end
        finish_phase(tbl_phase[N_TILES-1], N_TILES - 1);

        compare_val(64'(n_complete), 64'(tiles_sent), "store_complete pulse count");
        $display("All tests passed");
        $finish;
    end

endmodule
